/* Bender.yml */
package:
  name: axi_bram_rd

sources:
  - common/axi_rd_pkg.sv
  - common/bram_pkg.sv
  - common/rd_ctrl_if.sv
  - axi_read/axi_read_fsm.sv
  - axi_read/axi_read_addr_gen.sv
  - rtl/bram_array.sv
  - rtl/axi_bram_rd_top.sv
  - target: test
    files:
      - tb/tb_axi_bram_rd.sv

/* axi_read/axi_read_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_addr_gen (
  input  wire logic                        S_ACLK,
  input  wire logic                        S_ARESETN,
  input  wire logic [axi_rd_pkg::addr_w-1:0] araddr,
  input  wire axi_rd_pkg::len_t            arlen,
  input  wire axi_rd_pkg::size_t           arsize,
  input  wire axi_rd_pkg::burst_t          arburst,
  input  wire logic [axi_rd_pkg::id_w-1:0] arid,
  output logic [axi_rd_pkg::id_w-1:0]      rid,
  output logic [bram_pkg::waddr_w-1:0]     mem_addr,
  output logic                             mem_en,
  rd_ctrl_if.addr                          ctrl
);

  logic [axi_rd_pkg::addr_w-1:0] nbytes_c;
  axi_rd_pkg::size_t             size_c;
  axi_rd_pkg::burst_t            burst_q;
  logic [axi_rd_pkg::addr_w-1:0] nbytes_q;
  axi_rd_pkg::len_t              len_q;
  logic [axi_rd_pkg::addr_w-1:0] addr_q;
  logic [axi_rd_pkg::id_w-1:0]   id_q;
  axi_rd_pkg::len_t              cnt_q;

  // address of the beat after addr.
  function automatic logic [axi_rd_pkg::addr_w-1:0] next_addr(
    input logic [axi_rd_pkg::addr_w-1:0] addr,
    input axi_rd_pkg::burst_t            burst,
    input logic [axi_rd_pkg::addr_w-1:0] nbytes,
    input axi_rd_pkg::len_t              len
  );
    logic [axi_rd_pkg::addr_w-1:0] total;
    logic [axi_rd_pkg::addr_w-1:0] base;
    logic [axi_rd_pkg::addr_w-1:0] bound;
    logic [axi_rd_pkg::addr_w-1:0] result;
    total = nbytes * (axi_rd_pkg::addr_w'(len) + 1'b1);
    // wrap lengths are powers of two, so the window is aligned.
    base  = addr & ~(total - 1'b1);
    bound = base + total;
    case (burst)
      axi_rd_pkg::burst_fixed: begin
        result = addr;
      end
      axi_rd_pkg::burst_wrap: begin
        if (addr == bound - nbytes) begin
          result = base;
        end else begin
          result = addr + nbytes;
        end
      end
      default: begin
        result = addr + nbytes;
      end
    endcase
    return result;
  endfunction

  // sizes above the bus width are clamped.
  assign size_c   = (arsize > axi_rd_pkg::max_size) ? axi_rd_pkg::max_size : arsize;
  assign nbytes_c = axi_rd_pkg::addr_w'(1) << size_c;

  always_ff @(posedge S_ACLK) begin
    if (S_ARESETN) begin
      burst_q  <= axi_rd_pkg::burst_incr;
      nbytes_q <= '0;
      cnt_q    <= '0;
    end else if (ctrl.addr_en) begin
      burst_q  <= arburst;
      nbytes_q <= nbytes_c;
      cnt_q    <= arlen - 1'b1;
    end else if (ctrl.rd_en) begin
      cnt_q    <= cnt_q - 1'b1;
    end
  end

  // addr_q holds the address of the next beat to read.
  always_ff @(posedge S_ACLK) begin
    if (ctrl.addr_en) begin
      addr_q <= next_addr(araddr, arburst, nbytes_c, arlen);
      len_q  <= arlen;
      id_q   <= arid;
    end else if (ctrl.incr_addr) begin
      addr_q <= next_addr(addr_q, burst_q, nbytes_q, len_q);
    end
  end

  // rid follows the ram output register.
  always_ff @(posedge S_ACLK) begin
    if (ctrl.rd_en) begin
      rid <= ctrl.addr_en ? arid : id_q;
    end
  end

  assign ctrl.last_beat = ctrl.addr_en ? ctrl.single_trans : (cnt_q == '0);

  assign mem_addr = ctrl.mux_sel ?
                    addr_q[axi_rd_pkg::addr_w-1:bram_pkg::byte_sel_w] :
                    araddr[axi_rd_pkg::addr_w-1:bram_pkg::byte_sel_w];
  assign mem_en   = ctrl.rd_en;

endmodule

`default_nettype wire

/* axi_read/axi_read_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_fsm (
  input  wire logic             S_ACLK,
  input  wire logic             S_ARESETN,
  input  wire logic             arvalid,
  input  wire axi_rd_pkg::len_t arlen,
  input  wire logic             rready,
  output logic                  arready,
  output logic                  rvalid,
  output logic                  rlast,
  rd_ctrl_if.fsm                ctrl
);

  typedef enum logic [0:0] {
    st_idle  = 1'b0,
    st_burst = 1'b1
  } state_t;

  state_t state_q;
  logic   rvalid_q;
  logic   rlast_q;
  logic   ar_hs;
  logic   slot_free;

  // new AR only once the previous burst has fully drained.
  assign arready = (state_q == st_idle) && !rvalid_q;
  assign ar_hs   = arvalid && arready;

  // output slot is empty or being taken this cycle.
  assign slot_free = !rvalid_q || rready;

  assign ctrl.addr_en      = ar_hs;
  assign ctrl.mux_sel      = !ar_hs;
  assign ctrl.single_trans = (arlen == '0);

  // the rlast beat in the slot means all reads of the burst are issued.
  assign ctrl.rd_en = ar_hs ||
                      ((state_q == st_burst) && !rlast_q && slot_free);

  assign ctrl.incr_addr = ctrl.rd_en && !ctrl.last_beat;

  assign rvalid = rvalid_q;
  assign rlast  = rlast_q;

  // r output stage loads alongside the ram output register.
  always_ff @(posedge S_ACLK) begin
    if (S_ARESETN) begin
      rvalid_q <= 1'b0;
      rlast_q  <= 1'b0;
    end else if (ctrl.rd_en) begin
      rvalid_q <= 1'b1;
      rlast_q  <= ctrl.last_beat;
    end else if (rready) begin
      rvalid_q <= 1'b0;
      rlast_q  <= 1'b0;
    end
  end

  always_ff @(posedge S_ACLK) begin
    if (S_ARESETN) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: begin
          // a single beat is already read on the handshake.
          if (ar_hs && !ctrl.single_trans) begin
            state_q <= st_burst;
          end
        end
        st_burst: begin
          if (rvalid_q && rlast_q && rready) begin
            state_q <= st_idle;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* common/axi_rd_pkg.sv */
`default_nettype none

package axi_rd_pkg;

  // byte address and id widths on the AR/R channels.
  localparam int addr_w = 12;
  localparam int id_w   = 4;

  // arlen holds beats minus one.
  typedef logic [7:0] len_t;

  // arsize holds log2 of the bytes per beat.
  typedef logic [2:0] size_t;

  // 2'b11 is reserved and treated as incr.
  typedef enum logic [1:0] {
    burst_fixed = 2'b00,
    burst_incr  = 2'b01,
    burst_wrap  = 2'b10
  } burst_t;

  // widest beat of 4 bytes.
  localparam size_t max_size = 3'd2;

endpackage

`default_nettype wire

/* common/bram_pkg.sv */
`default_nettype none

package bram_pkg;

  localparam int data_w = 32;
  localparam int depth  = 1024;

  // word address into the array.
  localparam int waddr_w = $clog2(depth);

  // low byte address bits below a word.
  localparam int byte_sel_w = $clog2(data_w / 8);

  typedef logic [data_w-1:0] word_t;

endpackage

`default_nettype wire

/* common/rd_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rd_ctrl_if;

  logic addr_en;
  logic incr_addr;
  logic single_trans;
  logic mux_sel;
  logic last_beat;
  logic rd_en;

  modport fsm (
    output addr_en,
    output incr_addr,
    output single_trans,
    output mux_sel,
    output rd_en,
    input  last_beat
  );

  modport addr (
    input  addr_en,
    input  incr_addr,
    input  single_trans,
    input  mux_sel,
    input  rd_en,
    output last_beat
  );

endinterface

`default_nettype wire

/* rtl/axi_bram_rd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_bram_rd_top (
  input  wire logic                          S_ACLK,
  input  wire logic                          S_ARESETN,
  input  wire logic [axi_rd_pkg::addr_w-1:0] araddr,
  input  wire axi_rd_pkg::len_t              arlen,
  input  wire axi_rd_pkg::size_t             arsize,
  input  wire axi_rd_pkg::burst_t            arburst,
  input  wire logic [axi_rd_pkg::id_w-1:0]   arid,
  input  wire logic                          arvalid,
  output wire logic                          arready,
  output wire bram_pkg::word_t               rdata,
  output wire logic [axi_rd_pkg::id_w-1:0]   rid,
  output wire logic                          rlast,
  output wire logic                          rvalid,
  input  wire logic                          rready,
  input  wire logic                          wr_en,
  input  wire logic [bram_pkg::waddr_w-1:0]  wr_addr,
  input  wire bram_pkg::word_t               wr_data
);

  wire logic [bram_pkg::waddr_w-1:0] mem_addr;
  wire logic                         mem_en;

  rd_ctrl_if ctrl_if ();

  axi_read_fsm fsm_i (
    .S_ACLK    (S_ACLK),
    .S_ARESETN (S_ARESETN),
    .arvalid   (arvalid),
    .arlen     (arlen),
    .rready    (rready),
    .arready   (arready),
    .rvalid    (rvalid),
    .rlast     (rlast),
    .ctrl      (ctrl_if.fsm)
  );

  axi_read_addr_gen addr_gen_i (
    .S_ACLK    (S_ACLK),
    .S_ARESETN (S_ARESETN),
    .araddr    (araddr),
    .arlen     (arlen),
    .arsize    (arsize),
    .arburst   (arburst),
    .arid      (arid),
    .rid       (rid),
    .mem_addr  (mem_addr),
    .mem_en    (mem_en),
    .ctrl      (ctrl_if.addr)
  );

  bram_array ram_i (
    .S_ACLK  (S_ACLK),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (mem_en),
    .rd_addr (mem_addr),
    .rd_data (rdata)
  );

endmodule

`default_nettype wire

/* rtl/bram_array.sv */
`timescale 1ns/1ps
`default_nettype none

module bram_array (
  input  wire logic                         S_ACLK,
  input  wire logic                         wr_en,
  input  wire logic [bram_pkg::waddr_w-1:0] wr_addr,
  input  wire bram_pkg::word_t              wr_data,
  input  wire logic                         rd_en,
  input  wire logic [bram_pkg::waddr_w-1:0] rd_addr,
  output bram_pkg::word_t                   rd_data
);

  bram_pkg::word_t mem [0:bram_pkg::depth-1];

  always_ff @(posedge S_ACLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // output register holds while rd_en is low.
  always_ff @(posedge S_ACLK) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* src.f */
common/axi_rd_pkg.sv
common/bram_pkg.sv
common/rd_ctrl_if.sv
axi_read/axi_read_fsm.sv
axi_read/axi_read_addr_gen.sv
rtl/bram_array.sv
rtl/axi_bram_rd_top.sv
tb/tb_axi_bram_rd.sv

/* tb/tb_axi_bram_rd.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_bram_rd;

  // fill, sweep, incr, wrap, fixed, stall and back-to-back beats.
  localparam int total_beats = 1024 + 64 + 63 + 60 + 8 + 16 + 12;
  localparam int limit_cycles = total_beats * 20 + 200;

  logic                          S_ACLK;
  logic                          S_ARESETN;
  logic [axi_rd_pkg::addr_w-1:0] araddr;
  axi_rd_pkg::len_t              arlen;
  axi_rd_pkg::size_t             arsize;
  axi_rd_pkg::burst_t            arburst;
  logic [axi_rd_pkg::id_w-1:0]   arid;
  logic                          arvalid;
  logic                          arready;
  bram_pkg::word_t               rdata;
  logic [axi_rd_pkg::id_w-1:0]   rid;
  logic                          rlast;
  logic                          rvalid;
  logic                          rready;
  logic                          wr_en;
  logic [bram_pkg::waddr_w-1:0]  wr_addr;
  bram_pkg::word_t               wr_data;

  bram_pkg::word_t shadow [0:bram_pkg::depth-1];
  logic [31:0]     rng;
  int              errors;
  int              checks;
  int              tests;
  int              test_errors;

  axi_bram_rd_top dut_i (.*);

  initial begin
    S_ACLK = 1'b0;
    forever #2 S_ACLK = ~S_ACLK;
  end

  initial begin
    repeat (limit_cycles) @(posedge S_ACLK);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("Finished with errors");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // byte address of beat n within a burst.
  function automatic logic [axi_rd_pkg::addr_w-1:0] beat_addr(
    input int start,
    input int n,
    input int nbytes,
    input int beats,
    input axi_rd_pkg::burst_t burst
  );
    int total;
    int base;
    total = nbytes * beats;
    base  = (start / total) * total;
    case (burst)
      axi_rd_pkg::burst_fixed: return axi_rd_pkg::addr_w'(start);
      axi_rd_pkg::burst_wrap: begin
        return axi_rd_pkg::addr_w'(base + (start - base + n * nbytes) % total);
      end
      default:                 return axi_rd_pkg::addr_w'(start + n * nbytes);
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("test %-14s %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED", test_errors);
    tests++;
    test_errors = 0;
  endtask

  task automatic write_word(input int idx, input bram_pkg::word_t data);
    wr_en   = 1'b1;
    wr_addr = bram_pkg::waddr_w'(idx);
    wr_data = data;
    shadow[idx] = data;
    @(negedge S_ACLK);
    wr_en = 1'b0;
  endtask

  // issue one AR and collect every beat with optional random rready.
  task automatic read_burst(input int addr, input int len, input int size,
                            input axi_rd_pkg::burst_t burst, input int id, input bit stall);
    int                            beat;
    logic [axi_rd_pkg::addr_w-1:0] exp_addr;
    bram_pkg::word_t               held;
    bit                            holding;
    beat    = 0;
    holding = 1'b0;
    araddr  = axi_rd_pkg::addr_w'(addr);
    arlen   = axi_rd_pkg::len_t'(len);
    arsize  = axi_rd_pkg::size_t'(size);
    arburst = burst;
    arid    = axi_rd_pkg::id_w'(id);
    arvalid = 1'b1;
    while (!arready) @(negedge S_ACLK);
    @(negedge S_ACLK);
    arvalid = 1'b0;
    while (beat <= len) begin
      if (stall) begin
        rng    = xorshift(rng);
        rready = rng[0];
      end else begin
        rready = 1'b1;
      end
      // valid stays up for the whole burst from one cycle after AR.
      check_val("rvalid", 32'(1), 32'(rvalid));
      if (holding) begin
        check_val("rdata (stalled)", held, rdata);
      end
      exp_addr = beat_addr(addr, beat, 1 << size, len + 1, burst);
      if (rready) begin
        check_val("rdata", shadow[exp_addr[axi_rd_pkg::addr_w-1:2]], rdata);
        check_val("rid", 32'(id), 32'(rid));
        check_val("rlast", 32'(beat == len), 32'(rlast));
        beat++;
        holding = 1'b0;
      end else begin
        held    = rdata;
        holding = 1'b1;
      end
      @(negedge S_ACLK);
    end
    rready = 1'b0;
    check_val("arready", 32'(1), 32'(arready));
  endtask

  initial begin
    int a;
    int nb;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    test_errors = 0;
    rng         = 32'hfbe9;
    S_ARESETN   = 1'b1;
    araddr      = '0;
    arlen       = '0;
    arsize      = '0;
    arburst     = axi_rd_pkg::burst_incr;
    arid        = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    wr_en       = 1'b0;
    wr_addr     = '0;
    wr_data     = '0;
    repeat (5) @(negedge S_ACLK);
    S_ARESETN = 1'b0;
    check_val("arready", 32'(1), 32'(arready));
    check_val("rvalid", 32'(0), 32'(rvalid));
    check_val("rlast", 32'(0), 32'(rlast));
    for (int i = 0; i < bram_pkg::depth; i++) begin
      rng = xorshift(rng);
      write_word(i, rng);
    end
    end_test("reset_fill");

    for (int i = 0; i < 64; i++) begin
      a   = (i * 292) & 12'hffc;
      rng = xorshift(rng);
      write_word(a >> 2, rng);
      read_burst(a, 0, 2, axi_rd_pkg::burst_incr, i % 16, 1'b0);
    end
    end_test("single_sweep");

    for (int l = 0; l < 3; l++) begin
      for (int s = 0; s < 3; s++) begin
        read_burst(12'h200 + 64 * s + 256 * l, (1 << (2 * l)) - 1, s,
                   axi_rd_pkg::burst_incr, 3 * l + s, 1'b0);
      end
    end
    end_test("incr");

    // start three quarters into each window.
    for (int w = 0; w < 4; w++) begin
      for (int s = 1; s < 3; s++) begin
        nb = 1 << s;
        a  = 12'h400 + 128 * (2 * w + s) + nb * (((2 << w) * 3) / 4);
        read_burst(a, (2 << w) - 1, s, axi_rd_pkg::burst_wrap, w + 4 * s, 1'b0);
      end
    end
    end_test("wrap");

    read_burst(12'h7a4, 7, 2, axi_rd_pkg::burst_fixed, 5, 1'b0);
    end_test("fixed");

    read_burst(12'h600, 15, 2, axi_rd_pkg::burst_incr, 9, 1'b1);
    end_test("backpressure");

    for (int k = 0; k < 3; k++) begin
      read_burst(12'h800 + 16 * k, 3, 2, axi_rd_pkg::burst_incr, 10 + k, 1'b0);
    end
    end_test("back_to_back");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
